//--- Makefile
TB_TOP = iterator_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f iterator.f --top-module iterator_top

sim:
	verilator --binary --timing --assert -f iterator.f --top-module $(TB_TOP) -o iterator_sim
	@out=$$(./obj_dir/iterator_sim); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf obj_dir

//--- dv/iterator_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "iter_defs.svh"

module iterator_tb
	import iter_pkg::*;
;

	typedef struct packed {
		lane_sel_t sel;
		base_t base;
		stride_t s0;
		stride_t s1;
		stride_t s2;
	} lane_cfg_t;

	typedef struct packed {
		logic [`ITER_LOOP_ID_W-1:0] id;
		logic [`ITER_NUM_ITER_W-1:0] cnt;
	} level_t;

	// sets is the product of the counts with zero taken as one
	typedef struct packed {
		lane_cfg_t src1;
		lane_cfg_t src2;
		lane_cfg_t dest;
		level_t lv0;
		level_t lv1;
		level_t lv2;
		logic [7:0] duty;
		logic [15:0] sets;
	} row_t;

	localparam int NUM_ROWS = 6;

	logic clk = 1'b0;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [15:0] paddr;
	logic [31:0] pwdata;
	logic pready;
	logic pslverr;
	logic [31:0] prdata;
	logic instr_valid;
	iter_instr_t instr;
	logic instr_ready;
	logic out_valid;
	addr_set_t out_addr;
	logic out_last;
	logic out_ready;

	row_t rows [NUM_ROWS];
	int seed = 55992;
	int cycles = 0;
	int limit;

	// reference model state by loop level
	logic [15:0] m_cnt [8];
	logic [15:0] m_idx [8];
	stride_t m_stride [8][3];
	base_t m_base [3];

	iterator_top uut (
		.clk(clk), .reset(reset),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.pready(pready), .pslverr(pslverr), .prdata(prdata),
		.instr_valid(instr_valid), .instr(instr), .instr_ready(instr_ready),
		.out_valid(out_valid), .out_addr(out_addr), .out_last(out_last),
		.out_ready(out_ready)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			$display("Timeout: the run did not finish within %0d cycles", limit);
			$display("Result: FAILED");
			$fatal(1);
		end
	end

	task automatic stop_on_error(input string msg);
		$display("CHECK FAILED at %0t ns: %s", $time, msg);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	//////////////////////////////////////////////////
	// stimulus table
	//////////////////////////////////////////////////
	task automatic fill_table();
		rows[0] = '{'{'{3'd0, 5'd1}, 32'h0000_1000, 32'sd4, 32'sd8, 32'sd16},
			'{'{3'd1, 5'd2}, 32'h0000_2000, 32'sd1, 32'sd2, 32'sd3},
			'{'{3'd2, 5'd3}, 32'h8000_0000, 32'sd5, 32'sd6, 32'sd7},
			'{3'd0, 16'd0}, '{3'd1, 16'd0}, '{3'd2, 16'd0}, 8'd100, 16'd1};
		rows[1] = '{'{'{3'd3, 5'd0}, 32'h0001_0000, 32'sd4, 32'sd64, 32'sd0},
			'{'{3'd4, 5'd10}, 32'h0002_0000, -32'sd4, -32'sd64, 32'sd0},
			'{'{3'd5, 5'd31}, 32'h0000_0010, 32'sd1, 32'sd3, 32'sd0},
			'{3'd0, 16'd3}, '{3'd1, 16'd4}, '{3'd2, 16'd0}, 8'd100, 16'd12};
		rows[2] = '{'{'{3'd1, 5'd5}, 32'h0010_0000, 32'sd2, 32'sd20, 32'sd200},
			'{'{3'd2, 5'd6}, 32'hffff_fff0, 32'sd8, -32'sd8, 32'sd1},
			'{'{3'd0, 5'd7}, 32'h0000_0000, -32'sd1, -32'sd2, -32'sd3},
			'{3'd0, 16'd2}, '{3'd1, 16'd3}, '{3'd2, 16'd2}, 8'd60, 16'd12};
		rows[3] = '{'{'{3'd5, 5'd8}, 32'h0003_0000, 32'sd16, 32'sd32, 32'sd64},
			'{'{3'd3, 5'd9}, 32'h0004_0000, -32'sd16, 32'sd1, 32'sd0},
			'{'{3'd4, 5'd11}, 32'h0005_0000, 32'sd100, -32'sd100, 32'sd7},
			'{3'd7, 16'd2}, '{3'd0, 16'd3}, '{3'd3, 16'd0}, 8'd30, 16'd6};
		rows[4] = '{'{'{3'd0, 5'd20}, 32'h1000_0000, -32'sd3, 32'sh4000_0000, 32'sd12},
			'{'{3'd4, 5'd21}, 32'h2000_0000, 32'sd5, -32'sd7, 32'sd9},
			'{'{3'd1, 5'd22}, 32'h3000_0000, -32'sd1000, 32'sd250, -32'sd6},
			'{3'd1, 16'd4}, '{3'd4, 16'd1}, '{3'd2, 16'd3}, 8'd50, 16'd12};
		rows[5] = '{'{'{3'd2, 5'd12}, 32'h0000_0100, 32'sd4, 32'sd0, -32'sd32},
			'{'{3'd3, 5'd13}, 32'h0000_0200, 32'sd8, 32'sd0, 32'sd40},
			'{'{3'd5, 5'd14}, 32'h0000_0300, -32'sd12, 32'sd0, 32'sd3},
			'{3'd0, 16'd5}, '{3'd2, 16'd0}, '{3'd5, 16'd2}, 8'd80, 16'd10};
	endtask

	function automatic lane_cfg_t lane_of(row_t r, int k);
		case (k)
			0: return r.src1;
			1: return r.src2;
			default: return r.dest;
		endcase
	endfunction

	function automatic level_t level_of(row_t r, int j);
		case (j)
			0: return r.lv0;
			1: return r.lv1;
			default: return r.lv2;
		endcase
	endfunction

	function automatic stride_t stride_of(lane_cfg_t c, int j);
		case (j)
			0: return c.s0;
			1: return c.s1;
			default: return c.s2;
		endcase
	endfunction

	// strides of row level j sit j entries past the lane index
	function automatic lane_sel_t level_sel(lane_sel_t s, int j);
		lane_sel_t t;
		t.ns = s.ns;
		t.index = s.index + `ITER_INDEX_W'(j);
		return t;
	endfunction

	function automatic logic [15:0] table_addr(bit stride, logic [2:0] ns, logic [4:0] idx);
		return {5'd0, stride, ns, idx, 2'b00};
	endfunction

	function automatic iter_instr_t make_instr(logic [3:0] opcode, logic [3:0] fn,
			logic [2:0] loop_id, lane_sel_t s1, lane_sel_t s2, lane_sel_t d, logic [31:0] imm);
		iter_instr_t i;
		i.opcode = opcode;
		i.fn = fn;
		i.loop_id = loop_id;
		i.src1 = s1;
		i.src2 = s2;
		i.dest = d;
		i.immediate = imm;
		return i;
	endfunction

	function automatic bit ready_draw(int duty);
		int rnd;
		rnd = $random(seed);
		return ((rnd & 32'h7fff_ffff) % 100) < duty;
	endfunction

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////
	task automatic load_model(input row_t r, input bit bases_only);
		lane_cfg_t c;
		level_t lv;
		for (int l = 0; l < 8; l++) begin
			m_cnt[l] = 16'd0;
			m_idx[l] = 16'd0;
			for (int k = 0; k < 3; k++) begin
				m_stride[l][k] = 32'sd0;
			end
		end
		for (int k = 0; k < 3; k++) begin
			c = lane_of(r, k);
			m_base[k] = c.base;
		end
		if (!bases_only) begin
			for (int j = 0; j < 3; j++) begin
				lv = level_of(r, j);
				m_cnt[lv.id] = lv.cnt;
				for (int k = 0; k < 3; k++) begin
					c = lane_of(r, k);
					m_stride[lv.id][k] = stride_of(c, j);
				end
			end
		end
	endtask

	function automatic addr_t expected_addr(int k);
		addr_t a;
		a = m_base[k];
		for (int l = 0; l < 8; l++) begin
			a = a + addr_t'(m_idx[l]) * addr_t'(m_stride[l][k]);
		end
		return a;
	endfunction

	// level 0 rolls over first
	task automatic advance_index();
		int eff;
		for (int l = 0; l < 8; l++) begin
			eff = (m_cnt[l] == 16'd0) ? 1 : int'(m_cnt[l]);
			if (int'(m_idx[l]) + 1 < eff) begin
				m_idx[l] = m_idx[l] + 16'd1;
				return;
			end
			m_idx[l] = 16'd0;
		end
	endtask

	//////////////////////////////////////////////////
	// bus and instruction drivers
	//////////////////////////////////////////////////
	task automatic apb_access(input bit wr, input logic [15:0] addr, input logic [31:0] data,
			input bit exp_err);
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = data;
		@(negedge clk);
		penable = 1'b1;
		@(posedge clk);
		assert (pready && pslverr == exp_err && prdata == 32'd0)
		else stop_on_error($sformatf("apb at %h: pready %b pslverr %b prdata %h",
			addr, pready, pslverr, prdata));
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	// returns at the falling edge right after the handshake
	task automatic send_instr(input iter_instr_t i);
		@(negedge clk);
		instr = i;
		instr_valid = 1'b1;
		while (!instr_ready) begin
			@(negedge clk);
		end
		@(posedge clk);
		@(negedge clk);
		instr_valid = 1'b0;
	endtask

	task automatic run_loop(input lane_sel_t s1, input lane_sel_t s2, input lane_sel_t d,
			input int duty, input int sets);
		int lat;
		int n;
		bit rdy;
		bit held;
		bit prev_last;
		addr_set_t prev_addr;
		addr_set_t exp_set;
		send_instr(make_instr(`ITER_OPCODE_LOOP, `ITER_FN_START, 3'd0, s1, s2, d, 32'd0));
		lat = 0;
		while (!out_valid) begin
			assert (!instr_ready) else stop_on_error("instr_ready high while busy");
			@(negedge clk);
			lat++;
		end
		assert (lat == 3) else stop_on_error($sformatf("first out_valid after %0d cycles", lat));
		n = 0;
		held = 1'b0;
		prev_last = 1'b0;
		prev_addr = '0;
		while (n < sets) begin
			assert (out_valid && !instr_ready)
			else stop_on_error($sformatf("out_valid %b instr_ready %b before set %0d",
				out_valid, instr_ready, n));
			if (held) begin
				assert (out_addr == prev_addr && out_last == prev_last)
				else stop_on_error("output changed under back-pressure");
			end
			rdy = ready_draw(duty);
			out_ready = rdy;
			if (rdy) begin
				exp_set.src1 = expected_addr(0);
				exp_set.src2 = expected_addr(1);
				exp_set.dest = expected_addr(2);
				assert (out_addr == exp_set)
				else stop_on_error($sformatf("set %0d got %h expected %h", n, out_addr, exp_set));
				assert (out_last == (n == sets - 1))
				else stop_on_error($sformatf("out_last %b on set %0d of %0d", out_last, n, sets));
				n++;
				advance_index();
			end
			held = !rdy;
			prev_addr = out_addr;
			prev_last = out_last;
			@(negedge clk);
		end
		out_ready = 1'b0;
		assert (instr_ready && !out_valid && !out_last)
		else stop_on_error("iterator still busy after the last set");
	endtask

	task automatic apply_row(input row_t r);
		lane_cfg_t c;
		lane_sel_t s;
		level_t lv;
		for (int k = 0; k < 3; k++) begin
			c = lane_of(r, k);
			s = c.sel;
			apb_access(1'b1, table_addr(1'b0, s.ns, s.index), c.base, 1'b0);
			for (int j = 0; j < 3; j++) begin
				c.sel = level_sel(s, j);
				apb_access(1'b1, table_addr(1'b1, c.sel.ns, c.sel.index), stride_of(c, j), 1'b0);
			end
		end
		// neither of these may touch level 0
		send_instr(make_instr(4'd3, `ITER_FN_ITER, 3'd0, r.src1.sel, r.src2.sel, r.dest.sel,
			32'd9));
		send_instr(make_instr(`ITER_OPCODE_LOOP, 4'd5, 3'd0, r.src1.sel, r.src2.sel,
			r.dest.sel, 32'd9));
		for (int j = 0; j < 3; j++) begin
			lv = level_of(r, j);
			send_instr(make_instr(`ITER_OPCODE_LOOP, `ITER_FN_STRIDE, lv.id,
				level_sel(r.src1.sel, j), level_sel(r.src2.sel, j), level_sel(r.dest.sel, j),
				32'd0));
			send_instr(make_instr(`ITER_OPCODE_LOOP, `ITER_FN_ITER, lv.id, r.src1.sel,
				r.src2.sel, r.dest.sel, {16'd0, lv.cnt}));
		end
		load_model(r, 1'b0);
		run_loop(r.src1.sel, r.src2.sel, r.dest.sel, int'(r.duty), int'(r.sets));
	endtask

	initial begin
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 16'd0;
		pwdata = 32'd0;
		instr_valid = 1'b0;
		instr = '0;
		out_ready = 1'b0;
		fill_table();
		limit = 200 * NUM_ROWS;
		for (int r = 0; r < NUM_ROWS; r++) begin
			limit = limit + 2 * int'(rows[r].sets);
		end
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		assert (!out_valid && !out_last && instr_ready && !pslverr && !pready)
		else stop_on_error("outputs wrong after reset");

		for (int r = 0; r < NUM_ROWS; r++) begin
			apply_row(rows[r]);
		end

		// bad namespaces and reads must not alias onto a real slot
		apb_access(1'b1, table_addr(1'b0, 3'd6, rows[5].src1.sel.index), 32'hdead_beef, 1'b1);
		apb_access(1'b1, table_addr(1'b0, 3'd7, rows[5].src2.sel.index), 32'hdead_beef, 1'b1);
		apb_access(1'b0, table_addr(1'b0, rows[5].src1.sel.ns, rows[5].src1.sel.index),
			32'd0, 1'b1);

		// configuration was cleared by the last loop
		load_model(rows[5], 1'b1);
		run_loop(rows[5].src1.sel, rows[5].src2.sel, rows[5].dest.sel, 100, 1);

		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- hdl/iter_apb_cfg.sv
`timescale 1ns/1ps
`default_nettype none

`include "iter_defs.svh"

module iter_apb_cfg
	import iter_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [15:0] paddr,
	input wire [31:0] pwdata,
	output logic pready,
	output logic pslverr,
	output logic [31:0] prdata,
	output logic base_wr_en,
	output logic stride_wr_en,
	output tbl_wr_t tbl_wr
);

	logic access;
	logic ns_ok;
	logic wr_ok;
	logic [`ITER_NS_ID_W-1:0] ns;

	// namespace sits just below the table select bit
	assign ns = paddr[`ITER_APB_TABLE_BIT-1 -: `ITER_NS_ID_W];
	assign ns_ok = int'(ns) < `ITER_NUM_NS;

	assign access = psel & penable;
	assign wr_ok = access & pwrite & ns_ok;

	// zero wait, no readback
	assign pready = access;
	assign pslverr = access & (~pwrite | ~ns_ok);
	assign prdata = '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			base_wr_en <= 1'b0;
			stride_wr_en <= 1'b0;
		end else begin
			base_wr_en <= wr_ok & ~paddr[`ITER_APB_TABLE_BIT];
			stride_wr_en <= wr_ok & paddr[`ITER_APB_TABLE_BIT];
		end
	end

	always_ff @(posedge clk) begin
		if (wr_ok) begin
			tbl_wr.ns <= ns;
			tbl_wr.index <= paddr[2 +: `ITER_INDEX_W];
			tbl_wr.data <= pwdata;
		end
	end

endmodule

`default_nettype wire

//--- hdl/iter_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "iter_defs.svh"

module iter_decode
	import iter_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire instr_valid,
	input wire iter_instr_t instr,
	output logic instr_ready,
	input wire loop_done,
	output logic dec_valid,
	output dec_t dec
);

	logic busy;
	logic fire;
	op_kind_t kind;

	assign instr_ready = ~busy;
	assign fire = instr_valid & instr_ready;

	always_comb begin
		kind = op_none;
		if (instr.opcode == `ITER_OPCODE_LOOP) begin
			case (instr.fn)
				`ITER_FN_STRIDE: kind = op_stride;
				`ITER_FN_ITER: kind = op_iter;
				`ITER_FN_START: kind = op_start;
				default: kind = op_none;
			endcase
		end
	end

	// busy from start accept until the last set leaves
	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= fire;
			if (fire && kind == op_start) begin
				busy <= 1'b1;
			end else if (loop_done) begin
				busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fire) begin
			dec.kind <= kind;
			dec.loop_id <= instr.loop_id;
			dec.src1 <= instr.src1;
			dec.src2 <= instr.src2;
			dec.dest <= instr.dest;
			dec.count <= instr.immediate[`ITER_NUM_ITER_W-1:0];
		end
	end

endmodule

`default_nettype wire

//--- hdl/iter_defs.svh
`ifndef ITER_DEFS_SVH
`define ITER_DEFS_SVH

// namespace tables
`define ITER_NUM_NS        6
`define ITER_NS_ID_W       3
`define ITER_INDEX_W       5
`define ITER_TABLE_DEPTH   32
`define ITER_ADDR_W        32

// loop nest
`define ITER_MAX_LOOPS     8
`define ITER_LOOP_ID_W     3
`define ITER_NUM_ITER_W    16

// instruction encoding
`define ITER_OPCODE_W      4
`define ITER_FN_W          4
`define ITER_OPCODE_LOOP   `ITER_OPCODE_W'd7
`define ITER_FN_STRIDE     `ITER_FN_W'd0
`define ITER_FN_ITER       `ITER_FN_W'd1
`define ITER_FN_START      `ITER_FN_W'd2

// apb map, 0 selects base and 1 selects stride
`define ITER_APB_TABLE_BIT 10

`endif

//--- hdl/iter_pkg.sv
`default_nettype none

`include "iter_defs.svh"

package iter_pkg;

	typedef logic [`ITER_ADDR_W-1:0] base_t;
	typedef logic signed [`ITER_ADDR_W-1:0] stride_t;
	typedef logic [`ITER_ADDR_W-1:0] addr_t;

	typedef struct packed {
		logic [`ITER_NS_ID_W-1:0] ns;
		logic [`ITER_INDEX_W-1:0] index;
	} lane_sel_t;

	typedef struct packed {
		logic [`ITER_OPCODE_W-1:0] opcode;
		logic [`ITER_FN_W-1:0] fn;
		logic [`ITER_LOOP_ID_W-1:0] loop_id;
		lane_sel_t src1;
		lane_sel_t src2;
		lane_sel_t dest;
		logic [31:0] immediate;
	} iter_instr_t;

	typedef enum logic [1:0] {
		op_none,
		op_stride,
		op_iter,
		op_start
	} op_kind_t;

	// count is immediate[15:0]
	typedef struct packed {
		op_kind_t kind;
		logic [`ITER_LOOP_ID_W-1:0] loop_id;
		lane_sel_t src1;
		lane_sel_t src2;
		lane_sel_t dest;
		logic [`ITER_NUM_ITER_W-1:0] count;
	} dec_t;

	typedef struct packed {
		logic [`ITER_NS_ID_W-1:0] ns;
		logic [`ITER_INDEX_W-1:0] index;
		logic [`ITER_ADDR_W-1:0] data;
	} tbl_wr_t;

	typedef struct packed {
		addr_t src1;
		addr_t src2;
		addr_t dest;
	} addr_set_t;

endpackage

`default_nettype wire

//--- hdl/iter_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "iter_defs.svh"

module iter_table
	import iter_pkg::*;
#(
	parameter type entry_t = base_t
) (
	input wire clk,
	input wire wr_en,
	input wire tbl_wr_t wr,
	input wire lane_sel_t [2:0] rd_sel,
	output entry_t [2:0] rd_data
);

	// one bank per namespace
	entry_t mem [`ITER_NUM_NS][`ITER_TABLE_DEPTH];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr.ns][wr.index] <= entry_t'(wr.data);
		end
	end

	//////////////////////////////////////////////////
	// lane reads, src1 / src2 / dest
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		for (int i = 0; i < 3; i++) begin
			if (int'(rd_sel[i].ns) < `ITER_NUM_NS) begin
				rd_data[i] <= mem[rd_sel[i].ns][rd_sel[i].index];
			end else begin
				// unmapped namespace reads as zero
				rd_data[i] <= '0;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/iterator_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "iter_defs.svh"

module iterator_top
	import iter_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [15:0] paddr,
	input wire [31:0] pwdata,
	output logic pready,
	output logic pslverr,
	output logic [31:0] prdata,
	input wire instr_valid,
	input wire iter_instr_t instr,
	output logic instr_ready,
	output logic out_valid,
	output addr_set_t out_addr,
	output logic out_last,
	input wire out_ready
);

	logic base_wr_en;
	logic stride_wr_en;
	tbl_wr_t tbl_wr;
	logic dec_valid;
	dec_t dec;
	base_t [2:0] base_rd;
	stride_t [2:0] stride_rd;
	logic start;
	logic loop_done;
	base_t [2:0] lane_base;
	stride_t [2:0][`ITER_MAX_LOOPS-1:0] lane_stride;
	logic [`ITER_MAX_LOOPS-1:0][`ITER_NUM_ITER_W-1:0] level_count;

	iter_apb_cfg u_apb (
		.clk(clk), .reset(reset),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.pready(pready), .pslverr(pslverr), .prdata(prdata),
		.base_wr_en(base_wr_en), .stride_wr_en(stride_wr_en), .tbl_wr(tbl_wr)
	);

	// lane order is src1, src2, dest
	iter_table #(.entry_t(base_t)) u_base_tbl (
		.clk(clk), .wr_en(base_wr_en), .wr(tbl_wr),
		.rd_sel({dec.dest, dec.src2, dec.src1}), .rd_data(base_rd)
	);

	iter_table #(.entry_t(stride_t)) u_stride_tbl (
		.clk(clk), .wr_en(stride_wr_en), .wr(tbl_wr),
		.rd_sel({dec.dest, dec.src2, dec.src1}), .rd_data(stride_rd)
	);

	iter_decode u_decode (
		.clk(clk), .reset(reset),
		.instr_valid(instr_valid), .instr(instr), .instr_ready(instr_ready),
		.loop_done(loop_done), .dec_valid(dec_valid), .dec(dec)
	);

	loop_config u_config (
		.clk(clk), .reset(reset),
		.dec_valid(dec_valid), .dec(dec),
		.base_rd(base_rd), .stride_rd(stride_rd), .loop_done(loop_done),
		.start(start), .lane_base(lane_base),
		.lane_stride(lane_stride), .level_count(level_count)
	);

	loop_addr_gen u_addr_gen (
		.clk(clk), .reset(reset), .start(start),
		.lane_base(lane_base), .lane_stride(lane_stride), .level_count(level_count),
		.out_ready(out_ready), .out_valid(out_valid), .out_addr(out_addr),
		.out_last(out_last), .loop_done(loop_done)
	);

endmodule

`default_nettype wire

//--- hdl/loop_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "iter_defs.svh"

module loop_addr_gen
	import iter_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire start,
	input wire base_t [2:0] lane_base,
	input wire stride_t [2:0][`ITER_MAX_LOOPS-1:0] lane_stride,
	input wire [`ITER_MAX_LOOPS-1:0][`ITER_NUM_ITER_W-1:0] level_count,
	input wire out_ready,
	output logic out_valid,
	output addr_set_t out_addr,
	output logic out_last,
	output logic loop_done
);

	localparam int LOOPS = `ITER_MAX_LOOPS;
	localparam int CNT_W = `ITER_NUM_ITER_W;

	logic [LOOPS-1:0][CNT_W-1:0] idx;
	logic [LOOPS-1:0][CNT_W-1:0] idx_next;
	logic [LOOPS-1:0][CNT_W-1:0] idx_max;
	logic [LOOPS-1:0] at_end;
	logic [LOOPS-1:0] inc;
	logic [LOOPS-1:0] wrap;
	logic [LOOPS:0] carry;
	addr_t [2:0][LOOPS-1:0] contrib;
	addr_t [2:0][LOOPS-1:0] contrib_next;
	addr_t [2:0] lane_addr;
	addr_t [2:0] addr_next;
	addr_t [2:0] delta;
	logic fire;
	logic last_next;

	assign fire = out_valid & out_ready;
	assign loop_done = fire & out_last;

	//////////////////////////////////////////////////
	// level counters, innermost first
	//////////////////////////////////////////////////
	always_comb begin
		carry[0] = 1'b1;
		for (int l = 0; l < LOOPS; l++) begin
			// count of 0 runs once
			idx_max[l] = (level_count[l] == '0) ? '0 : level_count[l] - 1'b1;
			at_end[l] = idx[l] == idx_max[l];
			inc[l] = carry[l] & ~at_end[l];
			wrap[l] = carry[l] & at_end[l];
			carry[l+1] = wrap[l];
			idx_next[l] = wrap[l] ? '0 : idx[l] + CNT_W'(inc[l]);
		end
	end

	assign last_next = idx_next == idx_max;

	// per-level contribution is idx * stride, kept incrementally
	always_comb begin
		for (int k = 0; k < 3; k++) begin
			delta[k] = '0;
			for (int l = 0; l < LOOPS; l++) begin
				if (inc[l]) begin
					delta[k] = delta[k] + addr_t'(lane_stride[k][l]);
					contrib_next[k][l] = contrib[k][l] + addr_t'(lane_stride[k][l]);
				end else if (wrap[l]) begin
					delta[k] = delta[k] - contrib[k][l];
					contrib_next[k][l] = '0;
				end else begin
					contrib_next[k][l] = contrib[k][l];
				end
			end
			addr_next[k] = lane_addr[k] + delta[k];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			out_last <= 1'b0;
			idx <= '0;
		end else if (start) begin
			out_valid <= 1'b1;
			out_last <= idx_max == '0;
			idx <= '0;
		end else if (fire) begin
			out_valid <= ~out_last;
			out_last <= ~out_last & last_next;
			idx <= idx_next;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			contrib <= '0;
			lane_addr <= lane_base;
		end else if (fire) begin
			contrib <= contrib_next;
			lane_addr <= addr_next;
		end
	end

	assign out_addr = '{src1: lane_addr[0], src2: lane_addr[1], dest: lane_addr[2]};

endmodule

`default_nettype wire

//--- hdl/loop_config.sv
`timescale 1ns/1ps
`default_nettype none

`include "iter_defs.svh"

module loop_config
	import iter_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire dec_valid,
	input wire dec_t dec,
	input wire base_t [2:0] base_rd,
	input wire stride_t [2:0] stride_rd,
	input wire loop_done,
	output logic start,
	output base_t [2:0] lane_base,
	output stride_t [2:0][`ITER_MAX_LOOPS-1:0] lane_stride,
	output logic [`ITER_MAX_LOOPS-1:0][`ITER_NUM_ITER_W-1:0] level_count
);

	logic dec_d_valid;
	dec_t dec_d;

	// align with registered table reads
	always_ff @(posedge clk) begin
		if (reset) begin
			dec_d_valid <= 1'b0;
		end else begin
			dec_d_valid <= dec_valid;
		end
	end

	always_ff @(posedge clk) begin
		dec_d <= dec;
	end

	//////////////////////////////////////////////////
	// loop configuration capture
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset || loop_done) begin
			start <= 1'b0;
			lane_base <= '0;
			lane_stride <= '0;
			level_count <= '0;
		end else begin
			start <= dec_d_valid && dec_d.kind == op_start;
			if (dec_d_valid) begin
				case (dec_d.kind)
					op_stride: begin
						for (int k = 0; k < 3; k++) begin
							lane_stride[k][dec_d.loop_id] <= stride_rd[k];
						end
					end
					op_iter: level_count[dec_d.loop_id] <= dec_d.count;
					// bases only matter once the nest runs
					op_start: lane_base <= base_rd;
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- iterator.f
+incdir+hdl
hdl/iter_pkg.sv
hdl/iter_apb_cfg.sv
hdl/iter_table.sv
hdl/iter_decode.sv
hdl/loop_config.sv
hdl/loop_addr_gen.sv
hdl/iterator_top.sv
dv/iterator_tb.sv
